/* rtl/cpu_types_pkg.sv */
package cpu_types_pkg;

	// the processor moves 16-bit words and addresses memory by byte
	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;

	// one data or instruction word
	typedef logic [WORD_W-1:0] word_t;

	// a byte address where bit 0 is never used by the memory side
	typedef logic [ADDR_W-1:0] addr_t;

endpackage

/* rtl/cache_pkg.sv */
package cache_pkg;

	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);

	// the line address keeps everything above the word offset and the byte bit
	localparam int LINE_ADDR_W = cpu_types_pkg::ADDR_W - OFFSET_W - 1;

	typedef logic [OFFSET_W-1:0]    offset_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// controller states shared by the instruction and data cache
	typedef enum logic [1:0] {
		IDLE,
		WAIT_GNT,
		FILL,
		DONE
	} fill_state_e;

	function automatic line_addr_t line_of(cpu_types_pkg::addr_t addr);
		return addr[cpu_types_pkg::ADDR_W-1 -: LINE_ADDR_W];
	endfunction

	function automatic offset_t offset_of(cpu_types_pkg::addr_t addr);
		return addr[OFFSET_W:1];
	endfunction

	// rebuilds the byte address of one word inside a line
	function automatic cpu_types_pkg::addr_t word_addr(line_addr_t line, offset_t off);
		return {line, off, 1'b0};
	endfunction

endpackage

/* rtl/mem_req_if.sv */
interface mem_req_if;
	import cpu_types_pkg::*;

	logic  req;
	logic  gnt;
	logic  wr;
	addr_t addr;
	word_t wdata;
	word_t rdata;
	logic  data_valid;

	modport requester (
		output req, wr, addr, wdata,
		input  gnt, rdata, data_valid
	);

	modport arbiter_side (
		input  req, wr, addr, wdata,
		output gnt, rdata, data_valid
	);

	// the memory accepts every request it sees and never looks at gnt
	modport memory (
		input  req, wr, addr, wdata,
		output rdata, data_valid
	);

endinterface

/* rtl/icache.sv */
module icache #(
	parameter int NUM_LINES = 8
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 fetch_req_i,
	input  cpu_types_pkg::addr_t fetch_addr_i,
	output logic                 fetch_done_o,
	output cpu_types_pkg::word_t fetch_data_o,
	mem_req_if.requester         mem
);
	import cpu_types_pkg::*;
	import cache_pkg::*;

	localparam int      IDX_W     = $clog2(NUM_LINES);
	localparam offset_t LAST_WORD = offset_t'(WORDS_PER_LINE - 1);

	fill_state_e          state_q;
	logic                 pend_q;
	addr_t                addr_q;
	offset_t              iss_cnt_q;
	offset_t              rx_cnt_q;
	logic [NUM_LINES-1:0] valid_q;
	line_addr_t           tag_q  [NUM_LINES];
	word_t                data_q [NUM_LINES*WORDS_PER_LINE];

	line_addr_t       req_line;
	offset_t          req_off;
	logic [IDX_W-1:0] req_idx;
	logic             hit;

	assign req_line = line_of(addr_q);
	assign req_off  = offset_of(addr_q);
	assign req_idx  = req_line[IDX_W-1:0];
	assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_line);

	// a hit answers in the cycle after the strobe and a fill answers from DONE
	assign fetch_done_o = (state_q == IDLE && pend_q && hit) || (state_q == DONE);
	assign fetch_data_o = data_q[{req_idx, req_off}];

	// iss_cnt_q is back at zero between fills, so the first read asks for word 0
	assign mem.req   = (state_q == WAIT_GNT) || (state_q == FILL && iss_cnt_q != '0);
	assign mem.wr    = 1'b0;
	assign mem.addr  = word_addr(req_line, iss_cnt_q);
	assign mem.wdata = '0;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_q <= 1'b0;
		end else if (fetch_req_i) begin
			pend_q <= 1'b1;
		end else if (fetch_done_o) begin
			pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_req_i) begin
			addr_q <= fetch_addr_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q   <= IDLE;
			iss_cnt_q <= '0;
			rx_cnt_q  <= '0;
			valid_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (pend_q && !hit) begin
						state_q <= WAIT_GNT;
					end
				end
				WAIT_GNT: begin
					// the old contents of the line are gone from here on
					if (mem.gnt) begin
						state_q          <= FILL;
						iss_cnt_q        <= iss_cnt_q + 1'b1;
						valid_q[req_idx] <= 1'b0;
					end
				end
				FILL: begin
					if (mem.req) begin
						iss_cnt_q <= iss_cnt_q + 1'b1;
					end
					if (mem.data_valid) begin
						rx_cnt_q <= rx_cnt_q + 1'b1;
						if (rx_cnt_q == LAST_WORD) begin
							valid_q[req_idx] <= 1'b1;
							state_q          <= DONE;
						end
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// words come back in issue order, so the arrival count is the word offset
	always_ff @(posedge clk) begin
		if (state_q == FILL && mem.data_valid) begin
			data_q[{req_idx, rx_cnt_q}] <= mem.rdata;
			if (rx_cnt_q == LAST_WORD) begin
				tag_q[req_idx] <= req_line;
			end
		end
	end

endmodule

/* rtl/dcache.sv */
module dcache #(
	parameter int NUM_LINES = 8
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 data_req_i,
	input  logic                 data_wr_i,
	input  cpu_types_pkg::addr_t data_addr_i,
	input  cpu_types_pkg::word_t data_wdata_i,
	output logic                 data_done_o,
	output cpu_types_pkg::word_t data_rdata_o,
	mem_req_if.requester         mem
);
	import cpu_types_pkg::*;
	import cache_pkg::*;

	localparam int      IDX_W     = $clog2(NUM_LINES);
	localparam offset_t LAST_WORD = offset_t'(WORDS_PER_LINE - 1);

	fill_state_e          state_q;
	logic                 pend_q;
	logic                 wr_q;
	addr_t                addr_q;
	word_t                wdata_q;
	offset_t              iss_cnt_q;
	offset_t              rx_cnt_q;
	logic [NUM_LINES-1:0] valid_q;
	line_addr_t           tag_q  [NUM_LINES];
	word_t                data_q [NUM_LINES*WORDS_PER_LINE];

	line_addr_t       req_line;
	offset_t          req_off;
	logic [IDX_W-1:0] req_idx;
	logic             hit;
	logic             wr_accept;

	assign req_line = line_of(addr_q);
	assign req_off  = offset_of(addr_q);
	assign req_idx  = req_line[IDX_W-1:0];
	assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_line);

	// the cycle in which the memory takes the write-through
	assign wr_accept = (state_q == WAIT_GNT) && mem.gnt && wr_q;

	// only reads can finish straight from the array, writes always visit memory
	assign data_done_o  = (state_q == IDLE && pend_q && !wr_q && hit) || (state_q == DONE);
	assign data_rdata_o = data_q[{req_idx, req_off}];

	// a write is one request cycle, a read miss fetches the whole line
	assign mem.req   = (state_q == WAIT_GNT) || (state_q == FILL && iss_cnt_q != '0);
	assign mem.wr    = (state_q == WAIT_GNT) && wr_q;
	assign mem.addr  = wr_q ? addr_q : word_addr(req_line, iss_cnt_q);
	assign mem.wdata = wdata_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_q <= 1'b0;
			wr_q   <= 1'b0;
		end else if (data_req_i) begin
			pend_q <= 1'b1;
			wr_q   <= data_wr_i;
		end else if (data_done_o) begin
			pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (data_req_i) begin
			addr_q  <= data_addr_i;
			wdata_q <= data_wdata_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q   <= IDLE;
			iss_cnt_q <= '0;
			rx_cnt_q  <= '0;
			valid_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (pend_q && (wr_q || !hit)) begin
						state_q <= WAIT_GNT;
					end
				end
				WAIT_GNT: begin
					if (wr_accept) begin
						state_q <= DONE;
					end else if (mem.gnt) begin
						state_q          <= FILL;
						iss_cnt_q        <= iss_cnt_q + 1'b1;
						valid_q[req_idx] <= 1'b0;
					end
				end
				FILL: begin
					if (mem.req) begin
						iss_cnt_q <= iss_cnt_q + 1'b1;
					end
					if (mem.data_valid) begin
						rx_cnt_q <= rx_cnt_q + 1'b1;
						if (rx_cnt_q == LAST_WORD) begin
							valid_q[req_idx] <= 1'b1;
							state_q          <= DONE;
						end
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// a write that hits also patches the cached copy, a miss leaves it alone
	always_ff @(posedge clk) begin
		if (wr_accept && hit) begin
			data_q[{req_idx, req_off}] <= wdata_q;
		end else if (state_q == FILL && mem.data_valid) begin
			data_q[{req_idx, rx_cnt_q}] <= mem.rdata;
			if (rx_cnt_q == LAST_WORD) begin
				tag_q[req_idx] <= req_line;
			end
		end
	end

endmodule

/* rtl/mem_arbiter.sv */
module mem_arbiter (
	input  logic            clk,
	input  logic            rst_n_i,
	mem_req_if.arbiter_side icache_port,
	mem_req_if.arbiter_side dcache_port,
	mem_req_if.requester    mem
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ICACHE,
		ARB_DCACHE
	} arb_state_e;

	localparam offset_t LAST_WORD = offset_t'(WORDS_PER_LINE - 1);

	arb_state_e state_q;
	offset_t    rx_cnt_q;
	logic       icache_gnt;
	logic       dcache_gnt;
	logic       sel_icache;

	// grants are only handed out while the memory is free
	assign icache_gnt = (state_q == ARB_IDLE) && icache_port.req;
	assign dcache_gnt = (state_q == ARB_IDLE) && dcache_port.req && !icache_port.req;

	assign icache_port.gnt = icache_gnt;
	assign dcache_port.gnt = dcache_gnt;

	// when idle the instruction side goes first
	// once a fill runs its owner keeps the memory port
	assign sel_icache = (state_q == ARB_IDLE) ? icache_port.req : (state_q == ARB_ICACHE);

	assign mem.req   = sel_icache ? icache_port.req   : dcache_port.req;
	assign mem.wr    = sel_icache ? icache_port.wr    : dcache_port.wr;
	assign mem.addr  = sel_icache ? icache_port.addr  : dcache_port.addr;
	assign mem.wdata = sel_icache ? icache_port.wdata : dcache_port.wdata;

	assign icache_port.data_valid = (state_q == ARB_ICACHE) && mem.data_valid;
	assign dcache_port.data_valid = (state_q == ARB_DCACHE) && mem.data_valid;
	assign icache_port.rdata      = (state_q == ARB_ICACHE) ? mem.rdata : '0;
	assign dcache_port.rdata      = (state_q == ARB_DCACHE) ? mem.rdata : '0;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= ARB_IDLE;
			rx_cnt_q <= '0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					// a granted write is finished in its own cycle and needs no lock
					if (icache_gnt) begin
						state_q <= ARB_ICACHE;
					end else if (dcache_gnt && !dcache_port.wr) begin
						state_q <= ARB_DCACHE;
					end
				end
				default: begin
					if (mem.data_valid) begin
						rx_cnt_q <= rx_cnt_q + 1'b1;
						if (rx_cnt_q == LAST_WORD) begin
							state_q <= ARB_IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

/* rtl/main_mem.sv */
module main_mem #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS   = 32768
) (
	input  logic      clk,
	input  logic      rst_n_i,
	mem_req_if.memory bus
);
	import cpu_types_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	word_t                  mem_q [MEM_WORDS] = '{default: '0};
	logic [IDX_W-1:0]       word_idx;
	logic                   rd_en;
	logic [MEM_LATENCY-1:0] vld_q;
	word_t                  rd_q [MEM_LATENCY];

	// bit 0 picks a byte inside a word and is dropped here
	assign word_idx = bus.addr[IDX_W:1];
	assign rd_en    = bus.req && !bus.wr;

	always_ff @(posedge clk) begin
		if (bus.req && bus.wr) begin
			mem_q[word_idx] <= bus.wdata;
		end
	end

	// stage 0 is loaded at the accepting edge, so the last stage lands MEM_LATENCY later
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= rd_en;
			for (int i = 1; i < MEM_LATENCY; i++) begin
				vld_q[i] <= vld_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		rd_q[0] <= mem_q[word_idx];
		for (int i = 1; i < MEM_LATENCY; i++) begin
			rd_q[i] <= rd_q[i-1];
		end
	end

	assign bus.data_valid = vld_q[MEM_LATENCY-1];
	assign bus.rdata      = rd_q[MEM_LATENCY-1];

endmodule

/* rtl/mem_subsys.sv */
module mem_subsys #(
	parameter int NUM_LINES   = 8,
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS   = 32768
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 fetch_req_i,
	input  cpu_types_pkg::addr_t fetch_addr_i,
	output logic                 fetch_done_o,
	output cpu_types_pkg::word_t fetch_data_o,
	input  logic                 data_req_i,
	input  logic                 data_wr_i,
	input  cpu_types_pkg::addr_t data_addr_i,
	input  cpu_types_pkg::word_t data_wdata_i,
	output logic                 data_done_o,
	output cpu_types_pkg::word_t data_rdata_o
);

	// one channel per cache into the arbiter and one from the arbiter to memory
	mem_req_if icache_bus ();
	mem_req_if dcache_bus ();
	mem_req_if mem_bus ();

	icache #(
		.NUM_LINES(NUM_LINES)
	) u_icache (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_addr_i (fetch_addr_i),
		.fetch_done_o (fetch_done_o),
		.fetch_data_o (fetch_data_o),
		.mem          (icache_bus.requester)
	);

	dcache #(
		.NUM_LINES(NUM_LINES)
	) u_dcache (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.data_req_i   (data_req_i),
		.data_wr_i    (data_wr_i),
		.data_addr_i  (data_addr_i),
		.data_wdata_i (data_wdata_i),
		.data_done_o  (data_done_o),
		.data_rdata_o (data_rdata_o),
		.mem          (dcache_bus.requester)
	);

	mem_arbiter u_mem_arbiter (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.icache_port (icache_bus.arbiter_side),
		.dcache_port (dcache_bus.arbiter_side),
		.mem         (mem_bus.requester)
	);

	main_mem #(
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_WORDS   (MEM_WORDS)
	) u_main_mem (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.bus     (mem_bus.memory)
	);

endmodule

/* dv/mem_subsys_checker.sv */
module mem_subsys_checker #(
	parameter int NUM_LINES   = 8,
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS   = 32768
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 fetch_req_i,
	input  cpu_types_pkg::addr_t fetch_addr_i,
	input  logic                 fetch_done_i,
	input  cpu_types_pkg::word_t fetch_data_i,
	input  logic                 data_req_i,
	input  logic                 data_wr_i,
	input  cpu_types_pkg::addr_t data_addr_i,
	input  cpu_types_pkg::word_t data_wdata_i,
	input  logic                 data_done_i,
	input  cpu_types_pkg::word_t data_rdata_i,
	input  logic                 end_i,
	output int                   error_count_o,
	output int                   check_count_o,
	output int                   hit_count_o
);
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_types_pkg::*;

	localparam int WORDS_IN_LINE = 4;
	localparam int MISS_MIN      = MEM_LATENCY + 5;

	word_t ref_mem [MEM_WORDS] = '{default: '0};

	// the instruction cache keeps its own copy, it does not see data writes
	bit    ic_valid [NUM_LINES] = '{default: 1'b0};
	int    ic_tag   [NUM_LINES] = '{default: 0};
	word_t ic_data  [NUM_LINES][WORDS_IN_LINE];
	bit    dc_valid [NUM_LINES] = '{default: 1'b0};
	int    dc_tag   [NUM_LINES] = '{default: 0};

	addr_t fetch_addr_q [$];
	int    fetch_cyc_q  [$];
	bit    fetch_hit_q  [$];
	addr_t data_addr_q  [$];
	bit    data_wr_q    [$];
	word_t data_wdata_q [$];
	int    data_cyc_q   [$];
	bit    data_hit_q   [$];

	int cyc_cnt  = 0;
	int errors   = 0;
	int checks   = 0;
	int hits     = 0;
	bit end_seen = 1'b0;

	assign error_count_o = errors;
	assign check_count_o = checks;
	assign hit_count_o   = hits;

	// line number is the byte address without the byte bit and the word offset
	function automatic int line_number(addr_t a);
		return int'(a) >> 3;
	endfunction

	function automatic int word_number(addr_t a);
		return (int'(a) >> 1) % MEM_WORDS;
	endfunction

	function automatic bit icache_holds(addr_t a);
		int idx;
		idx = line_number(a) % NUM_LINES;
		return ic_valid[idx] && (ic_tag[idx] == line_number(a));
	endfunction

	function automatic bit dcache_holds(addr_t a);
		int idx;
		idx = line_number(a) % NUM_LINES;
		return dc_valid[idx] && (dc_tag[idx] == line_number(a));
	endfunction

	task automatic compare_word(string what, addr_t a, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t: %s at address %h returned %h, expected %h",
				$time, what, a, got, exp);
		end
	endtask

	task automatic check_latency(string what, addr_t a, bit hit, int lat);
		checks++;
		if (hit && lat != 1) begin
			errors++;
			$display("FAILED %0t: %s hit at address %h took %0d cycles, expected 1",
				$time, what, a, lat);
		end else if (!hit && lat < MISS_MIN) begin
			errors++;
			$display("FAILED %0t: %s miss at address %h took %0d cycles, expected %0d or more",
				$time, what, a, lat, MISS_MIN);
		end
	endtask

	// a fill sees every write that completed before the fetch completes
	task automatic finish_fetch();
		addr_t a;
		int    lat;
		bit    hit;
		int    line;
		int    idx;
		if (fetch_addr_q.size() == 0) begin
			errors++;
			$display("error at %0t: fetch completion seen with no fetch outstanding", $time);
		end else begin
			a    = fetch_addr_q.pop_front();
			lat  = cyc_cnt - fetch_cyc_q.pop_front();
			hit  = fetch_hit_q.pop_front();
			line = line_number(a);
			idx  = line % NUM_LINES;
			if (hit) begin
				hits++;
			end else begin
				for (int k = 0; k < WORDS_IN_LINE; k++) begin
					ic_data[idx][k] = ref_mem[(line * WORDS_IN_LINE + k) % MEM_WORDS];
				end
				ic_valid[idx] = 1'b1;
				ic_tag[idx]   = line;
			end
			compare_word("fetch", a, fetch_data_i, ic_data[idx][word_number(a) % WORDS_IN_LINE]);
			check_latency("fetch", a, hit, lat);
		end
	endtask

	task automatic finish_data();
		addr_t a;
		int    lat;
		bit    wr;
		bit    hit;
		word_t wd;
		int    idx;
		if (data_addr_q.size() == 0) begin
			errors++;
			$display("error at %0t: data completion seen with no data request outstanding", $time);
		end else begin
			a   = data_addr_q.pop_front();
			lat = cyc_cnt - data_cyc_q.pop_front();
			wr  = data_wr_q.pop_front();
			hit = data_hit_q.pop_front();
			wd  = data_wdata_q.pop_front();
			idx = line_number(a) % NUM_LINES;
			if (wr) begin
				ref_mem[word_number(a)] = wd;
			end else begin
				if (hit) begin
					hits++;
				end else begin
					dc_valid[idx] = 1'b1;
					dc_tag[idx]   = line_number(a);
				end
				compare_word("data read", a, data_rdata_i, ref_mem[word_number(a)]);
				check_latency("data read", a, hit, lat);
			end
		end
	endtask

	task automatic report_missing();
		foreach (fetch_addr_q[i]) begin
			errors++;
			$display("error: fetch of address %h from cycle %0d never completed",
				fetch_addr_q[i], fetch_cyc_q[i]);
		end
		foreach (data_addr_q[i]) begin
			errors++;
			$display("error: data request to address %h from cycle %0d never completed",
				data_addr_q[i], data_cyc_q[i]);
		end
	endtask

	// completions are looked at in the middle of the cycle that carries them
	always @(negedge clk) begin
		cyc_cnt++;
		if (rst_n_i) begin
			if (data_done_i) begin
				finish_data();
			end
			if (fetch_done_i) begin
				finish_fetch();
			end
		end
	end

	// requests are taken at the rising edge that registers them in the DUT
	always @(posedge clk) begin
		if (rst_n_i) begin
			if (data_req_i) begin
				data_addr_q.push_back(data_addr_i);
				data_wr_q.push_back(data_wr_i);
				data_wdata_q.push_back(data_wdata_i);
				data_cyc_q.push_back(cyc_cnt);
				data_hit_q.push_back(dcache_holds(data_addr_i));
			end
			if (fetch_req_i) begin
				fetch_addr_q.push_back(fetch_addr_i);
				fetch_cyc_q.push_back(cyc_cnt);
				fetch_hit_q.push_back(icache_holds(fetch_addr_i));
			end
			if (end_i && !end_seen) begin
				end_seen = 1'b1;
				report_missing();
			end
		end
	end

endmodule

/* dv/tb_mem_subsys.sv */
module tb_mem_subsys;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_types_pkg::*;

	localparam int          NUM_LINES     = 8;
	localparam int          MEM_LATENCY   = 4;
	localparam int          MEM_WORDS     = 32768;
	localparam int          REQS_PER_PORT = 300;
	localparam int          WINDOW_BYTES  = 256;
	localparam logic [31:0] SEED          = 32'hf8bc9cda;

	// a request can wait behind a fill of the other cache before its own fill
	localparam int MAX_CYCLES = 2 * REQS_PER_PORT * (MEM_LATENCY + 20);

	logic  clk = 1'b0;
	logic  rst_n;
	logic  fetch_req;
	addr_t fetch_addr;
	logic  fetch_done;
	word_t fetch_data;
	logic  data_req;
	logic  data_wr;
	addr_t data_addr;
	word_t data_wdata;
	logic  data_done;
	word_t data_rdata;

	logic  run_end;
	logic  timed_out;
	logic  stop_checks;
	int    cycle_cnt = 0;
	int    error_count;
	int    check_count;
	int    hit_count;

	assign stop_checks = run_end || timed_out;

	always #10 clk = ~clk;

	mem_subsys #(
		.NUM_LINES   (NUM_LINES),
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_WORDS   (MEM_WORDS)
	) u_mem_subsys (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.fetch_req_i  (fetch_req),
		.fetch_addr_i (fetch_addr),
		.fetch_done_o (fetch_done),
		.fetch_data_o (fetch_data),
		.data_req_i   (data_req),
		.data_wr_i    (data_wr),
		.data_addr_i  (data_addr),
		.data_wdata_i (data_wdata),
		.data_done_o  (data_done),
		.data_rdata_o (data_rdata)
	);

	mem_subsys_checker #(
		.NUM_LINES   (NUM_LINES),
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_WORDS   (MEM_WORDS)
	) u_checker (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.fetch_req_i   (fetch_req),
		.fetch_addr_i  (fetch_addr),
		.fetch_done_i  (fetch_done),
		.fetch_data_i  (fetch_data),
		.data_req_i    (data_req),
		.data_wr_i     (data_wr),
		.data_addr_i   (data_addr),
		.data_wdata_i  (data_wdata),
		.data_done_i   (data_done),
		.data_rdata_i  (data_rdata),
		.end_i         (stop_checks),
		.error_count_o (error_count),
		.check_count_o (check_count),
		.hit_count_o   (hit_count)
	);

	// a small window keeps lines reused and makes fetch and data overlap often
	function automatic addr_t pick_addr();
		return addr_t'($urandom_range(WINDOW_BYTES - 1, 0));
	endfunction

	task automatic idle_gap();
		int gap;
		gap = int'($urandom_range(3, 0));
		repeat (gap) @(negedge clk);
	endtask

	task automatic run_fetches();
		for (int n = 0; n < REQS_PER_PORT; n++) begin
			fetch_addr = pick_addr();
			fetch_req  = 1'b1;
			@(negedge clk);
			fetch_req = 1'b0;
			while (!fetch_done) begin
				@(negedge clk);
			end
			idle_gap();
		end
	endtask

	task automatic run_data_accesses();
		for (int n = 0; n < REQS_PER_PORT; n++) begin
			data_addr  = pick_addr();
			data_wr    = ($urandom_range(9, 0) < 4);
			data_wdata = word_t'($urandom());
			data_req   = 1'b1;
			@(negedge clk);
			data_req = 1'b0;
			while (!data_done) begin
				@(negedge clk);
			end
			idle_gap();
		end
	endtask

	task automatic print_summary();
		$display("errors: %0d, checks: %0d, cache hits: %0d, cycles: %0d",
			error_count, check_count, hit_count, cycle_cnt);
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n      = 1'b0;
		run_end    = 1'b0;
		fetch_req  = 1'b0;
		fetch_addr = '0;
		data_req   = 1'b0;
		data_wr    = 1'b0;
		data_addr  = '0;
		data_wdata = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		// both ports run on their own so that misses collide at the arbiter
		fork
			run_fetches();
			run_data_accesses();
		join

		repeat (2) @(negedge clk);
		run_end = 1'b1;
		repeat (2) @(negedge clk);
		print_summary();
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		timed_out = 1'b0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		timed_out = 1'b1;
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		repeat (2) @(posedge clk);
		print_summary();
		$display("Test failed");
		$finish;
	end

endmodule

/* sources.f */
rtl/cpu_types_pkg.sv
rtl/cache_pkg.sv
rtl/mem_req_if.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/main_mem.sv
rtl/mem_subsys.sv
dv/mem_subsys_checker.sv
dv/tb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_mem_subsys
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module "$TOP" -f sources.f -o "$TOP"; then
	echo "run.sh: verilator build failed"
	exit 1
fi

if ! ./obj_dir/"$TOP" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "run.sh: simulation exited with an error status"
	exit 1
fi

cat "$LOG"

if grep -qx "Test passed" "$LOG"; then
	exit 0
fi

echo "run.sh: pass message not found in $LOG"
exit 1
